// File: filelist.f
rtl/cameraPkg.sv
rtl/syncTiming.sv
rtl/grayPacker.sv
rtl/lineBuffer.sv
rtl/frameWriter.sv
rtl/cameraRegs.sv
rtl/cameraTop.sv
verification/cameraTb.sv

// File: rtl/cameraPkg.sv
package cameraPkg;

  localparam int dataWidth = 32;
  localparam int countWidth = 11;      // bytes per line and lines per frame
  localparam int maxLineWords = 256;   // words per bank
  localparam int wordIndexWidth = 8;

  // register offsets on the control slave
  localparam logic [7:0] regBytesPerLine = 8'h00;
  localparam logic [7:0] regLinesPerFrame = 8'h04;
  localparam logic [7:0] regFrameBase = 8'h10;
  localparam logic [7:0] regControl = 8'h18;
  localparam logic [7:0] regStatus = 8'h1C;

  typedef struct packed {
    logic hsync;
    logic vsync;
    logic [7:0] data;
  } camIn_t;

  typedef struct packed {
    logic cyc;
    logic stb;
    logic we;
    logic [dataWidth-1:0] adr;
    logic [dataWidth-1:0] dat;
    logic [dataWidth/8-1:0] sel;
  } wbReq_t;

  typedef struct packed {
    logic ack;
    logic [dataWidth-1:0] dat;
  } wbRsp_t;

  typedef struct packed {
    logic frameStart;                    // one cycle after vsync falls
    logic lineEnd;                       // one cycle after hsync falls
    logic [countWidth-1:0] byteIndex;    // index of the byte on the bus now
    logic active;
    logic [countWidth-1:0] bytesPerLine;
    logic [countWidth-1:0] linesPerFrame;
  } lineTiming_t;

  typedef struct packed {
    logic we;
    logic bank;
    logic [wordIndexWidth-1:0] wordIndex;
    logic [dataWidth-1:0] data;
  } pixWrite_t;

  typedef struct packed {
    logic [dataWidth-1:0] frameBase;     // word aligned
    logic continuous;
    logic singleRequest;
  } captureCtrl_t;

endpackage

// File: rtl/cameraRegs.sv
module cameraRegs (
  input  logic                    pclk,
  input  logic                    reset,
  input  cameraPkg::wbReq_t       ctrlReq,
  output cameraPkg::wbRsp_t       ctrlRsp,
  input  cameraPkg::lineTiming_t  timing,
  input  logic                    singleDone,
  input  logic                    overrun,
  output cameraPkg::captureCtrl_t ctrl
);
  import cameraPkg::*;

  logic ack;
  logic writeEn;
  logic [7:0] offset;
  logic [dataWidth-1:0] frameBase;
  logic continuous;
  logic singleRequest;
  logic singleDoneFlag;   // sticky
  logic overrunFlag;      // sticky

  assign offset = ctrlReq.adr[7:0];
  assign writeEn = ack && ctrlReq.cyc && ctrlReq.stb && ctrlReq.we;

  always_ff @(posedge pclk) begin
    if (reset) begin
      ack <= 1'b0;
      frameBase <= '0;
      continuous <= 1'b0;
      singleRequest <= 1'b0;
      singleDoneFlag <= 1'b0;
      overrunFlag <= 1'b0;
    end else begin
      ack <= ctrlReq.cyc && ctrlReq.stb && !ack;
      if (timing.frameStart) begin
        singleRequest <= 1'b0;
      end
      if (singleDone) begin
        singleDoneFlag <= 1'b1;
      end
      if (overrun) begin
        overrunFlag <= 1'b1;
      end
      if (writeEn) begin
        case (offset)
          regFrameBase: frameBase <= {ctrlReq.dat[dataWidth-1:2], 2'b00};
          regControl: begin
            continuous <= ctrlReq.dat[1:0] == 2'd1;
            singleRequest <= ctrlReq.dat[1:0] == 2'd2;
            if (ctrlReq.dat[1:0] == 2'd2) begin
              singleDoneFlag <= 1'b0;
            end
          end
          regStatus: begin
            if (ctrlReq.dat[1]) begin
              overrunFlag <= 1'b0;   // write one to clear
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    ctrlRsp.ack = ack;
    case (offset)
      regBytesPerLine: ctrlRsp.dat = dataWidth'(timing.bytesPerLine);
      regLinesPerFrame: ctrlRsp.dat = dataWidth'(timing.linesPerFrame);
      regFrameBase: ctrlRsp.dat = frameBase;
      regControl: ctrlRsp.dat = dataWidth'({singleRequest, continuous});
      regStatus: ctrlRsp.dat = dataWidth'({overrunFlag, singleDoneFlag});
      default: ctrlRsp.dat = '0;
    endcase
  end

  always_comb begin
    ctrl.frameBase = frameBase;
    ctrl.continuous = continuous;
    ctrl.singleRequest = singleRequest;
  end

endmodule

// File: rtl/cameraTop.sv
module cameraTop (
  input  logic              pclk,
  input  logic              reset,
  input  cameraPkg::camIn_t cam,
  input  cameraPkg::wbReq_t ctrlReq,
  output cameraPkg::wbRsp_t ctrlRsp,
  output cameraPkg::wbReq_t memReq,
  input  cameraPkg::wbRsp_t memRsp
);
  import cameraPkg::*;

  lineTiming_t timing;
  pixWrite_t pixWrite;
  captureCtrl_t ctrl;
  logic doneBank;
  logic readBank;
  logic [wordIndexWidth-1:0] readIndex;
  logic [dataWidth-1:0] readData;
  logic singleDone;
  logic overrun;

  syncTiming i_syncTiming (
    .pclk(pclk),
    .reset(reset),
    .cam(cam),
    .timing(timing)
  );

  grayPacker i_grayPacker (
    .pclk(pclk),
    .reset(reset),
    .cam(cam),
    .timing(timing),
    .pixWrite(pixWrite),
    .doneBank(doneBank)
  );

  lineBuffer i_lineBuffer (
    .pclk(pclk),
    .pixWrite(pixWrite),
    .readBank(readBank),
    .readIndex(readIndex),
    .readData(readData)
  );

  frameWriter i_frameWriter (
    .pclk(pclk),
    .reset(reset),
    .timing(timing),
    .doneBank(doneBank),
    .ctrl(ctrl),
    .readBank(readBank),
    .readIndex(readIndex),
    .readData(readData),
    .memReq(memReq),
    .memRsp(memRsp),
    .singleDone(singleDone),
    .overrun(overrun)
  );

  cameraRegs i_cameraRegs (
    .pclk(pclk),
    .reset(reset),
    .ctrlReq(ctrlReq),
    .ctrlRsp(ctrlRsp),
    .timing(timing),
    .singleDone(singleDone),
    .overrun(overrun),
    .ctrl(ctrl)
  );

endmodule

// File: rtl/frameWriter.sv
module frameWriter (
  input  logic                                 pclk,
  input  logic                                 reset,
  input  cameraPkg::lineTiming_t               timing,
  input  logic                                 doneBank,
  input  cameraPkg::captureCtrl_t              ctrl,
  output logic                                 readBank,
  output logic [cameraPkg::wordIndexWidth-1:0] readIndex,
  input  logic [cameraPkg::dataWidth-1:0]      readData,
  output cameraPkg::wbReq_t                    memReq,
  input  cameraPkg::wbRsp_t                    memRsp,
  output logic                                 singleDone,
  output logic                                 overrun
);
  import cameraPkg::*;

  typedef enum logic [1:0] {
    idle,
    prefetch,
    transfer
  } writerState_t;

  writerState_t state;
  logic capturing;       // this frame goes to memory
  logic singleFrame;     // this frame is a single shot
  logic [dataWidth-1:0] writeAddr;
  logic [wordIndexWidth-1:0] wordsLeft;
  logic [wordIndexWidth-1:0] lineWords;
  logic startLine;

  assign lineWords = timing.bytesPerLine[wordIndexWidth+2:3];
  assign startLine = timing.lineEnd && capturing && lineWords != '0;

  always_ff @(posedge pclk) begin
    if (reset) begin
      state <= idle;
      capturing <= 1'b0;
      singleFrame <= 1'b0;
      singleDone <= 1'b0;
      overrun <= 1'b0;
      writeAddr <= '0;
      wordsLeft <= '0;
      readBank <= 1'b0;
      readIndex <= '0;
      memReq <= '0;
    end else begin
      singleDone <= timing.frameStart && singleFrame;
      overrun <= startLine && state != idle;   // new line dropped
      case (state)
        idle: begin
          if (startLine) begin
            readBank <= doneBank;
            readIndex <= '0;
            wordsLeft <= lineWords;
            state <= prefetch;
          end
        end
        prefetch: begin
          state <= transfer;     // read word lands in readData
        end
        transfer: begin
          if (!memReq.stb) begin
            memReq.cyc <= 1'b1;
            memReq.stb <= 1'b1;
            memReq.we <= 1'b1;
            memReq.sel <= '1;
            memReq.adr <= writeAddr;
            memReq.dat <= readData;
          end else if (memRsp.ack) begin
            memReq.stb <= 1'b0;
            writeAddr <= writeAddr + dataWidth'(4);
            wordsLeft <= wordsLeft - wordIndexWidth'(1);
            readIndex <= readIndex + wordIndexWidth'(1);
            if (wordsLeft == wordIndexWidth'(1)) begin
              memReq.cyc <= 1'b0;   // end of line
              memReq.we <= 1'b0;
              state <= idle;
            end else begin
              state <= prefetch;
            end
          end
        end
        default: state <= idle;
      endcase
      // frame decision, a pending single request is consumed here
      if (timing.frameStart) begin
        capturing <= ctrl.continuous || ctrl.singleRequest;
        singleFrame <= ctrl.singleRequest;
        writeAddr <= ctrl.frameBase;
      end
    end
  end

endmodule

// File: rtl/grayPacker.sv
module grayPacker (
  input  logic                   pclk,
  input  logic                   reset,
  input  cameraPkg::camIn_t      cam,
  input  cameraPkg::lineTiming_t timing,
  output cameraPkg::pixWrite_t   pixWrite,
  output logic                   doneBank
);
  import cameraPkg::*;

  logic [7:0] highByte;
  logic [23:0] wordAcc;      // gray bytes 0..2 of the current word
  logic curBank;
  logic [15:0] rgb;
  logic [7:0] red;
  logic [7:0] green;
  logic [7:0] blue;
  logic [15:0] weighted;
  logic [7:0] gray;
  logic wrEnable;
  logic wrBank;
  logic [wordIndexWidth-1:0] wrIndex;
  logic [dataWidth-1:0] wrData;

  assign rgb = {highByte, cam.data};
  assign red = {rgb[15:11], 3'b000};
  assign green = {rgb[10:5], 2'b00};
  assign blue = {rgb[4:0], 3'b000};
  assign weighted = 16'd77 * {8'd0, red} + 16'd150 * {8'd0, green} + 16'd29 * {8'd0, blue};
  assign gray = weighted[15:8];

  // during lineEnd the bank has not toggled yet
  assign doneBank = timing.lineEnd ? curBank : ~curBank;

  always_ff @(posedge pclk) begin
    if (reset) begin
      curBank <= 1'b0;
      wrEnable <= 1'b0;
    end else begin
      wrEnable <= timing.active && timing.byteIndex[2:0] == 3'd7;
      if (timing.lineEnd) begin
        curBank <= ~curBank;
      end
    end
  end

  always_ff @(posedge pclk) begin
    if (timing.active) begin
      case (timing.byteIndex[2:0])
        3'd1: wordAcc[7:0] <= gray;
        3'd3: wordAcc[15:8] <= gray;
        3'd5: wordAcc[23:16] <= gray;
        3'd7: begin
          wrData <= {gray, wordAcc};   // first pixel in the low byte
          wrIndex <= timing.byteIndex[wordIndexWidth+2:3];
          wrBank <= curBank;
        end
        default: highByte <= cam.data;
      endcase
    end
  end

  always_comb begin
    pixWrite.we = wrEnable;
    pixWrite.bank = wrBank;
    pixWrite.wordIndex = wrIndex;
    pixWrite.data = wrData;
  end

endmodule

// File: rtl/lineBuffer.sv
module lineBuffer (
  input  logic                                pclk,
  input  cameraPkg::pixWrite_t                pixWrite,
  input  logic                                readBank,
  input  logic [cameraPkg::wordIndexWidth-1:0] readIndex,
  output logic [cameraPkg::dataWidth-1:0]      readData
);
  import cameraPkg::*;

  // bank select is the top address bit
  logic [dataWidth-1:0] mem [0:2*maxLineWords-1];

  always_ff @(posedge pclk) begin
    if (pixWrite.we) begin
      mem[{pixWrite.bank, pixWrite.wordIndex}] <= pixWrite.data;
    end
  end

  always_ff @(posedge pclk) begin
    readData <= mem[{readBank, readIndex}];
  end

endmodule

// File: rtl/syncTiming.sv
module syncTiming (
  input  logic                   pclk,
  input  logic                   reset,
  input  cameraPkg::camIn_t      cam,
  output cameraPkg::lineTiming_t timing
);
  import cameraPkg::*;

  logic hsyncPrev;
  logic vsyncPrev;
  logic hsyncFall;
  logic vsyncFall;
  logic frameStart;
  logic lineEnd;
  logic [countWidth-1:0] byteCount;
  logic [countWidth-1:0] lineCount;
  logic [countWidth-1:0] bytesPerLine;
  logic [countWidth-1:0] linesPerFrame;

  assign hsyncFall = hsyncPrev & ~cam.hsync;
  assign vsyncFall = vsyncPrev & ~cam.vsync;

  always_ff @(posedge pclk) begin
    if (reset) begin
      hsyncPrev <= 1'b0;
      vsyncPrev <= 1'b0;
      frameStart <= 1'b0;
      lineEnd <= 1'b0;
      byteCount <= '0;
      lineCount <= '0;
      bytesPerLine <= '0;
      linesPerFrame <= '0;
    end else begin
      hsyncPrev <= cam.hsync;
      vsyncPrev <= cam.vsync;
      frameStart <= vsyncFall;
      lineEnd <= hsyncFall;
      if (hsyncFall) begin
        bytesPerLine <= byteCount;   // finished line length
        byteCount <= '0;
      end else if (cam.hsync) begin
        byteCount <= byteCount + countWidth'(1);
      end
      if (vsyncFall) begin
        linesPerFrame <= lineCount;
        lineCount <= '0;
      end else if (hsyncFall) begin
        lineCount <= lineCount + countWidth'(1);
      end
    end
  end

  always_comb begin
    timing.frameStart = frameStart;
    timing.lineEnd = lineEnd;
    timing.byteIndex = byteCount;
    timing.active = cam.hsync;       // byte on the bus is valid
    timing.bytesPerLine = bytesPerLine;
    timing.linesPerFrame = linesPerFrame;
  end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the camera capture testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module cameraTb

# the simulator exits nonzero on a fatal check, the log decides the result
./obj_dir/VcameraTb > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi

echo "simulation finished without failures"
exit 0

// File: verification/cameraTb.sv
module cameraTb;
  timeunit 1ns;
  timeprecision 100ps;

  import cameraPkg::*;

  localparam int numFrames = 6;
  localparam int vsyncCycles = 6;
  localparam int frontCycles = 10;

  logic pclk = 1'b0;
  logic reset;
  camIn_t cam;
  wbReq_t ctrlReq;
  wbRsp_t ctrlRsp;
  wbReq_t memReq;
  wbRsp_t memRsp = '0;

  int frameWidth [numFrames];
  int frameLines [numFrames];
  logic [7:0] pixels [];
  logic [31:0] frameBase;
  int limitCycles = 0;
  int frameTag = 0;         // bumped per frame so the slave clears its store
  int stallTag = -1;        // frame whose first ack is held back
  int stallLength = 0;

  // memory slave
  logic [31:0] memStore [logic [31:0]];
  int seenTag = 0;
  int stallUsedTag = -1;
  int ackWait = -1;
  int writeCount = 0;
  logic cycSeen = 1'b0;

  always #20 pclk = ~pclk;

  cameraTop i_cameraTop (
    .pclk(pclk),
    .reset(reset),
    .cam(cam),
    .ctrlReq(ctrlReq),
    .ctrlRsp(ctrlRsp),
    .memReq(memReq),
    .memRsp(memRsp)
  );

  task automatic abortRun();
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic checkValue(string name, logic [31:0] got, logic [31:0] expected);
    if (got !== expected) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, expected);
      abortRun();
    end
  endtask

  function automatic logic [7:0] grayOf(logic [7:0] hi, logic [7:0] lo);
    int r;
    int g;
    int b;
    r = hi[7:3] * 8;
    g = {hi[2:0], lo[7:5]} * 4;
    b = lo[4:0] * 8;
    return 8'((77 * r + 150 * g + 29 * b) / 256);
  endfunction

  // word k of frame f with the first pixel in the low byte
  function automatic logic [31:0] expectedWord(int f, int k);
    int words;
    int base;
    int p;
    logic [31:0] word;
    words = frameWidth[f] / 8;
    base = (k / words) * frameWidth[f] + (k % words) * 8;
    word = '0;
    for (p = 0; p < 4; p++) begin
      word[8*p +: 8] = grayOf(pixels[base + 2*p], pixels[base + 2*p + 1]);
    end
    return word;
  endfunction

  always @(negedge pclk) begin
    if (seenTag != frameTag) begin
      memStore.delete();
      writeCount = 0;
      cycSeen = 1'b0;
      seenTag = frameTag;
    end
    if (memReq.cyc) begin
      cycSeen = 1'b1;
    end
    if (memRsp.ack) begin
      memRsp.ack = 1'b0;   // single cycle ack
    end else if (memReq.cyc && memReq.stb) begin
      if (ackWait < 0) begin
        if (stallTag == seenTag && stallUsedTag != seenTag) begin
          ackWait = stallLength;
          stallUsedTag = seenTag;
        end else begin
          ackWait = $urandom_range(3, 0);
        end
      end
      if (ackWait == 0) begin
        checkValue("memReq.we", 32'(memReq.we), 32'h1);
        checkValue("memReq.sel", 32'(memReq.sel), 32'hf);
        memStore[memReq.adr] = memReq.dat;
        writeCount++;
        memRsp.ack = 1'b1;
        ackWait = -1;
      end else begin
        ackWait--;
      end
    end
  end

  task automatic busAccess(logic isWrite, logic [7:0] offset, logic [31:0] wdata,
                           output logic [31:0] rdata);
    int waitCycles;
    @(negedge pclk);
    ctrlReq.cyc = 1'b1;
    ctrlReq.stb = 1'b1;
    ctrlReq.we = isWrite;
    ctrlReq.adr = 32'(offset);
    ctrlReq.dat = wdata;
    ctrlReq.sel = '1;
    waitCycles = 0;
    @(negedge pclk);
    while (!ctrlRsp.ack) begin
      waitCycles++;
      if (waitCycles > 8) begin
        $display("control port never acknowledged offset 0x%h", offset);
        abortRun();
      end else begin
        @(negedge pclk);
      end
    end
    rdata = ctrlRsp.dat;
    @(negedge pclk);        // hold through the ack edge
    ctrlReq = '0;
  endtask

  task automatic regWrite(logic [7:0] offset, logic [31:0] value);
    logic [31:0] ignored;
    busAccess(1'b1, offset, value, ignored);
  endtask

  task automatic regCheck(string name, logic [7:0] offset, logic [31:0] expected);
    logic [31:0] value;
    busAccess(1'b0, offset, '0, value);
    checkValue(name, value, expected);
  endtask

  task automatic sendVsync();
    @(negedge pclk);
    cam.vsync = 1'b1;
    repeat (vsyncCycles) @(negedge pclk);
    cam.vsync = 1'b0;
    repeat (frontCycles) @(negedge pclk);
  endtask

  task automatic sendLine(int line, int width);
    int blank;
    int b;
    blank = 4 * (width / 8) + 10;
    for (b = 0; b < width; b++) begin
      @(negedge pclk);
      cam.hsync = 1'b1;
      cam.data = pixels[line * width + b];
    end
    @(negedge pclk);
    cam.hsync = 1'b0;
    cam.data = 8'h00;
    repeat (blank) @(negedge pclk);
  endtask

  // leading vsync starts the frame and trailing vsync latches its height
  task automatic driveFrame(int f);
    int n;
    frameTag++;
    pixels = new[frameLines[f] * frameWidth[f]];
    for (n = 0; n < frameLines[f] * frameWidth[f]; n++) begin
      pixels[n] = 8'($urandom);
    end
    repeat (2) @(negedge pclk);
    sendVsync();
    for (n = 0; n < frameLines[f]; n++) begin
      sendLine(n, frameWidth[f]);
    end
    while (memReq.cyc) @(negedge pclk);   // last line still going out
    sendVsync();
    regCheck("bytesPerLine", regBytesPerLine, 32'(frameWidth[f]));
    regCheck("linesPerFrame", regLinesPerFrame, 32'(frameLines[f]));
  endtask

  task automatic checkFrame(int f);
    int total;
    int k;
    logic [31:0] addr;
    total = frameLines[f] * (frameWidth[f] / 8);
    checkValue("memory write count", 32'(writeCount), 32'(total));
    for (k = 0; k < total; k++) begin
      addr = frameBase + 32'(4 * k);
      if (!memStore.exists(addr)) begin
        $display("no memory write seen at address 0x%h", addr);
        abortRun();
      end else begin
        checkValue("memReq.dat", memStore[addr], expectedWord(f, k));
      end
    end
  endtask

  initial begin
    wait (limitCycles > 0);
    repeat (limitCycles) @(posedge pclk);
    $display("simulation timed out after %0d cycles", limitCycles);
    abortRun();
  end

  initial begin
    int sum;
    int f;
    logic [31:0] oddBase;
    void'($urandom(32'heb2bc6cb));
    reset = 1'b1;
    cam = '0;
    ctrlReq = '0;
    sum = 0;
    for (f = 0; f < numFrames; f++) begin
      frameWidth[f] = 8 * $urandom_range(32, 1);
      frameLines[f] = $urandom_range(5, 2);
      sum += 2 * (vsyncCycles + frontCycles + 2) + 400
             + frameLines[f] * (frameWidth[f] + 4 * (frameWidth[f] / 8) + 12);
    end
    stallLength = frameWidth[5] + 4 * (frameWidth[5] / 8) + 30;  // beyond one line period
    limitCycles = 2 * (sum + stallLength) + 10000;
    repeat (10) @(negedge pclk);
    reset = 1'b0;

    regCheck("bytesPerLine", regBytesPerLine, '0);
    regCheck("linesPerFrame", regLinesPerFrame, '0);
    regCheck("frameBase", regFrameBase, '0);
    regCheck("control", regControl, '0);
    regCheck("status", regStatus, '0);
    driveFrame(0);
    checkValue("memReq.cyc", 32'(cycSeen), 32'h0);

    oddBase = $urandom | 32'h3;
    regWrite(regFrameBase, oddBase);
    regCheck("frameBase", regFrameBase, oddBase & 32'hffff_fffc);

    frameBase = $urandom & 32'h7fff_fffc;
    regWrite(regFrameBase, frameBase);
    regWrite(regControl, 32'd1);
    driveFrame(1);
    checkFrame(1);
    driveFrame(2);
    checkFrame(2);

    regWrite(regControl, 32'd2);
    regCheck("status", regStatus, 32'h0);
    driveFrame(3);
    checkFrame(3);
    regCheck("status", regStatus, 32'h1);
    driveFrame(4);
    checkValue("memReq.cyc", 32'(cycSeen), 32'h0);

    regWrite(regControl, 32'd1);
    stallTag = frameTag + 1;
    driveFrame(5);
    regCheck("status", regStatus, 32'h3);
    regWrite(regStatus, 32'h2);
    regCheck("status", regStatus, 32'h1);
    regWrite(regControl, 32'd2);       // a new single request clears singleDone
    regCheck("status", regStatus, 32'h0);
    regWrite(regControl, 32'd0);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule
